// ==== hdl/rv_mem_pkg.sv ====
package rv_mem_pkg;

    // Data path and register file widths
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;

    // One bit per byte lane, low means write that lane
    typedef logic [3:0]  byte_wen_t;

    // Memory width codes from funct3 (FLW and FSW use the word code)
    localparam funct3_t F3_B  = 3'd0;
    localparam funct3_t F3_H  = 3'd1;
    localparam funct3_t F3_W  = 3'd2;
    localparam funct3_t F3_BU = 3'd4;
    localparam funct3_t F3_HU = 3'd5;

    // Byte write enables
    localparam byte_wen_t WEN_IDLE = 4'b1111;
    localparam byte_wen_t WEN_WORD = 4'b0000;

    // Data memory geometry and default latency
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);
    localparam int MEM_WAIT  = 1;

    typedef logic [MEM_AW-1:0] word_idx_t;

    // Bundle handed over by the execute stage
    typedef struct packed {
        logic      valid;
        xlen_t     alu_out;
        xlen_t     r_alu_out;
        reg_addr_t write_addr;
        funct3_t   funct3;
        xlen_t     pc;
        xlen_t     store_data;
        logic      rd_src;
        logic      mem_to_reg;
        logic      mem_write;
        logic      mem_read;
        logic      reg_write;
        logic      f_reg_write;
    } exe_out_t;

    // EX/MEM contents, store data already shifted into its lanes
    typedef struct packed {
        logic      valid;
        xlen_t     alu_out;
        xlen_t     r_alu_out;
        reg_addr_t write_addr;
        funct3_t   funct3;
        xlen_t     pc;
        xlen_t     store_data;
        logic      rd_src;
        logic      mem_to_reg;
        byte_wen_t mem_wen;
        logic      mem_read;
        logic      reg_write;
        logic      f_reg_write;
    } exmem_t;

    // Writeback to the integer and float register files
    typedef struct packed {
        logic      reg_write;
        logic      f_reg_write;
        reg_addr_t write_addr;
        xlen_t     data;
        xlen_t     pc;
    } wb_t;

endpackage

// ==== hdl/exe_mem_reg.sv ====
module exe_mem_reg
    import rv_mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  exe_out_t exe,
    input  logic     im_stall,
    input  logic     dm_stall,
    output exmem_t   exmem
);

    byte_wen_t wen_next;
    xlen_t     store_next;

    // Lane enables and data alignment for stores
    always_comb begin
        wen_next   = WEN_IDLE;
        store_next = exe.store_data;
        if (exe.mem_write) begin
            case (exe.funct3)
                F3_B: begin
                    case (exe.alu_out[1:0])
                        2'd0: begin
                            wen_next = 4'b1110;
                        end
                        2'd1: begin
                            wen_next   = 4'b1101;
                            store_next = {16'd0, exe.store_data[7:0], 8'd0};
                        end
                        2'd2: begin
                            wen_next   = 4'b1011;
                            store_next = {8'd0, exe.store_data[7:0], 16'd0};
                        end
                        default: begin
                            wen_next   = 4'b0111;
                            store_next = {exe.store_data[7:0], 24'd0};
                        end
                    endcase
                end
                F3_H: begin
                    if (exe.alu_out[1]) begin
                        wen_next   = 4'b0011;
                        store_next = {exe.store_data[15:0], 16'd0};
                    end else begin
                        wen_next = 4'b1100;
                    end
                end
                // SW and FSW
                default: begin
                    wen_next = WEN_WORD;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem <= '{mem_wen: WEN_IDLE, default: '0};
        end else if (im_stall && !dm_stall) begin
            // Memory finishes this cycle, so keep it from running again
            exmem.mem_wen  <= WEN_IDLE;
            exmem.mem_read <= 1'b0;
            exmem.valid    <= 1'b0;
        end else if (!dm_stall) begin
            exmem.valid       <= exe.valid;
            exmem.alu_out     <= exe.alu_out;
            exmem.r_alu_out   <= exe.r_alu_out;
            exmem.write_addr  <= exe.write_addr;
            exmem.funct3      <= exe.funct3;
            exmem.pc          <= exe.pc;
            exmem.store_data  <= store_next;
            exmem.rd_src      <= exe.rd_src;
            exmem.mem_to_reg  <= exe.mem_to_reg;
            exmem.mem_wen     <= wen_next;
            exmem.mem_read    <= exe.mem_read;
            exmem.reg_write   <= exe.reg_write;
            exmem.f_reg_write <= exe.f_reg_write;
        end
        // dm_stall holds everything
    end

endmodule

// ==== hdl/data_mem.sv ====
module data_mem
    import rv_mem_pkg::*;
#(
    parameter int WAIT = MEM_WAIT
) (
    input  logic   clk,
    input  logic   reset,
    input  exmem_t exmem,
    output logic   dm_stall,
    output xlen_t  load_word
);

    localparam int CNT_W = (WAIT > 1) ? $clog2(WAIT) : 1;

    xlen_t            mem [MEM_WORDS];
    word_idx_t        idx;
    logic             access;
    logic             busy;
    logic [CNT_W-1:0] cnt;

    assign idx    = exmem.alu_out[MEM_AW+1:2];
    assign access = exmem.valid && (exmem.mem_read || exmem.mem_wen != WEN_IDLE);

    // First cycle of an access stalls unless WAIT is zero
    assign dm_stall = access && (busy ? (cnt != '0) : (WAIT != 0));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (!access) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (!busy) begin
            if (WAIT != 0) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(WAIT - 1);
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            // Access done, next one starts fresh
            busy <= 1'b0;
            cnt  <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !dm_stall) begin
            for (int i = 0; i < 4; i++) begin
                if (!exmem.mem_wen[i]) begin
                    mem[idx][8*i +: 8] <= exmem.store_data[8*i +: 8];
                end
            end
        end
    end

    assign load_word = mem[idx];

endmodule

// ==== hdl/mem_wb_reg.sv ====
module mem_wb_reg
    import rv_mem_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  exmem_t exmem,
    input  xlen_t  load_word,
    input  logic   dm_stall,
    output wb_t    wb
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    xlen_t       load_ext;
    xlen_t       wb_data;

    // Pick the addressed byte and half out of the word
    always_comb begin
        case (exmem.alu_out[1:0])
            2'd0:    load_byte = load_word[7:0];
            2'd1:    load_byte = load_word[15:8];
            2'd2:    load_byte = load_word[23:16];
            default: load_byte = load_word[31:24];
        endcase
        load_half = exmem.alu_out[1] ? load_word[31:16] : load_word[15:0];
    end

    always_comb begin
        case (exmem.funct3)
            F3_B:    load_ext = {{24{load_byte[7]}}, load_byte};
            F3_BU:   load_ext = {24'd0, load_byte};
            F3_H:    load_ext = {{16{load_half[15]}}, load_half};
            F3_HU:   load_ext = {16'd0, load_half};
            default: load_ext = load_word;
        endcase
    end

    // Writeback source: load, link value or ALU result
    always_comb begin
        if (exmem.mem_to_reg) begin
            wb_data = load_ext;
        end else if (exmem.rd_src) begin
            wb_data = exmem.r_alu_out;
        end else begin
            wb_data = exmem.alu_out;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else if (dm_stall) begin
            // Bubble while memory is still busy
            wb.reg_write   <= 1'b0;
            wb.f_reg_write <= 1'b0;
        end else begin
            wb.reg_write   <= exmem.valid && exmem.reg_write;
            wb.f_reg_write <= exmem.valid && exmem.f_reg_write;
            wb.write_addr  <= exmem.write_addr;
            wb.data        <= wb_data;
            wb.pc          <= exmem.pc;
        end
    end

endmodule

// ==== hdl/mem_stage_top.sv ====
module mem_stage_top
    import rv_mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  exe_out_t exe,
    input  logic     im_stall,
    output wb_t      wb,
    output logic     dm_stall
);

    exmem_t exmem;
    xlen_t  load_word;

    exe_mem_reg u_exe_mem_reg (
        .clk      (clk),
        .reset    (reset),
        .exe      (exe),
        .im_stall (im_stall),
        .dm_stall (dm_stall),
        .exmem    (exmem)
    );

    data_mem #(
        .WAIT (MEM_WAIT)
    ) u_data_mem (
        .clk       (clk),
        .reset     (reset),
        .exmem     (exmem),
        .dm_stall  (dm_stall),
        .load_word (load_word)
    );

    // Retires on the edge where memory completes
    mem_wb_reg u_mem_wb_reg (
        .clk       (clk),
        .reset     (reset),
        .exmem     (exmem),
        .load_word (load_word),
        .dm_stall  (dm_stall),
        .wb        (wb)
    );

endmodule

// ==== test/mem_stage_properties.sv ====
module mem_stage_properties
    import rv_mem_pkg::*;
#(
    parameter int WAIT = MEM_WAIT
) (
    input logic   clk,
    input logic   reset,
    input logic   im_stall,
    input logic   dm_stall,
    input exmem_t exmem
);
    timeunit 1ns;
    timeprecision 100ps;

    // Stall cycles seen in a row before this one
    int stall_run;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stall_run <= 0;
        end else if (dm_stall) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    a_im_stall_clears: assert property (@(posedge clk) disable iff (reset)
        (im_stall && !dm_stall) |=> (exmem.mem_wen == WEN_IDLE && !exmem.mem_read
                                     && !exmem.valid))
        else $error("memory controls not cleared after im_stall only cycle");

    a_stall_length: assert property (@(posedge clk) disable iff (reset)
        dm_stall |-> (stall_run < WAIT))
        else $error("dm_stall lasted longer than the wait count");

    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        dm_stall |=> $stable(exmem))
        else $error("EX/MEM register changed during dm_stall");

endmodule

bind exe_mem_reg mem_stage_properties u_properties (
    .clk      (clk),
    .reset    (reset),
    .im_stall (im_stall),
    .dm_stall (dm_stall),
    .exmem    (exmem)
);

// ==== test/mem_stage_monitor.sv ====
module mem_stage_monitor
    import rv_mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  exe_out_t exe,
    input  logic     im_stall,
    input  logic     dm_stall,
    input  wb_t      wb,
    input  logic     done,
    output int       errors,
    output int       pending
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] model [1024];
    wb_t        expq [$];
    logic       reported;
    int         stall_left;

    assign pending = expq.size();

    task automatic apply_store(input exe_out_t e);
        logic [9:0] base;
        base = {e.alu_out[9:2], 2'b00};
        case (e.funct3)
            F3_B: begin
                model[base + 10'(e.alu_out[1:0])] = e.store_data[7:0];
            end
            F3_H: begin
                model[base + {8'd0, e.alu_out[1], 1'b0}]        = e.store_data[7:0];
                model[base + {8'd0, e.alu_out[1], 1'b0} + 10'd1] = e.store_data[15:8];
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    model[base + 10'(k)] = e.store_data[8*k +: 8];
                end
            end
        endcase
    endtask

    function automatic xlen_t load_value(input exe_out_t e);
        logic [9:0]  base;
        xlen_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        base = {e.alu_out[9:2], 2'b00};
        w = {model[base + 10'd3], model[base + 10'd2], model[base + 10'd1], model[base]};
        b = w[{e.alu_out[1:0], 3'b000} +: 8];
        h = w[{e.alu_out[1], 4'b0000} +: 16];
        case (e.funct3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'd0, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'd0, h};
            default: return w;
        endcase
    endfunction

    task automatic compare_field(input string name, input xlen_t expv, input xlen_t act);
        if (expv !== act) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expv, act);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        wb_t w;
        if (reset) begin
            errors     = 0;
            reported   = 1'b0;
            stall_left = 0;
        end else begin
            // Retirement check against the oldest pending row
            if (wb.reg_write || wb.f_reg_write) begin
                if (expq.size() == 0) begin
                    $display("Writeback at %0t with no instruction pending", $time);
                    errors++;
                end else begin
                    w = expq.pop_front();
                    compare_field("wb.reg_write", xlen_t'(w.reg_write), xlen_t'(wb.reg_write));
                    compare_field("wb.f_reg_write", xlen_t'(w.f_reg_write),
                                  xlen_t'(wb.f_reg_write));
                    compare_field("wb.write_addr", xlen_t'(w.write_addr),
                                  xlen_t'(wb.write_addr));
                    compare_field("wb.data", w.data, wb.data);
                    compare_field("wb.pc", w.pc, wb.pc);
                end
            end
            // Each memory access stalls for the wait count, nothing else stalls
            compare_field("dm_stall", xlen_t'(stall_left != 0), xlen_t'(dm_stall));
            if (stall_left != 0) begin
                stall_left--;
            end
            // Capture edge of the EX/MEM register
            if (exe.valid && !im_stall && !dm_stall) begin
                if (exe.mem_read || exe.mem_write) begin
                    stall_left = MEM_WAIT;
                end
                if (exe.mem_write) begin
                    apply_store(exe);
                end
                if (exe.reg_write || exe.f_reg_write) begin
                    w.reg_write   = exe.reg_write;
                    w.f_reg_write = exe.f_reg_write;
                    w.write_addr  = exe.write_addr;
                    w.pc          = exe.pc;
                    if (exe.mem_read) begin
                        w.data = load_value(exe);
                    end else if (exe.rd_src) begin
                        w.data = exe.r_alu_out;
                    end else begin
                        w.data = exe.alu_out;
                    end
                    expq.push_back(w);
                end
            end
            if (done && !reported) begin
                reported = 1'b1;
                if (expq.size() != 0) begin
                    $display("%0d instructions never retired", expq.size());
                    errors++;
                end
            end
        end
    end

endmodule

// ==== test/mem_stage_tb.sv ====
module mem_stage_tb
    import rv_mem_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ROWS    = 24;
    localparam int TIMEOUT   = N_ROWS * (4 + MEM_WAIT + 3) + 100;
    localparam int DRAIN_MAX = 4 + MEM_WAIT + 3;

    // Row kinds
    localparam logic [1:0] K_ALU   = 2'd0;
    localparam logic [1:0] K_STORE = 2'd1;
    localparam logic [1:0] K_LOAD  = 2'd2;

    // Gap column value that asks for a random im_stall gap
    localparam logic [2:0] RND = 3'd7;

    // addr is the ALU result for K_ALU rows; wr is {float, int}
    typedef struct packed {
        logic [1:0] kind;
        funct3_t    f3;
        xlen_t      addr;
        xlen_t      data;
        logic [1:0] wr;
        logic       rd_src;
        xlen_t      link;
        reg_addr_t  waddr;
        logic [2:0] gap;
    } row_t;

    logic     clk;
    logic     reset;
    exe_out_t exe;
    logic     im_stall;
    wb_t      wb;
    logic     dm_stall;
    logic     done;
    int       mon_errors;
    int       pending;
    int       cycles;
    logic [31:0] lfsr;
    row_t     rows [N_ROWS];

    mem_stage_top DUT (
        .clk      (clk),
        .reset    (reset),
        .exe      (exe),
        .im_stall (im_stall),
        .wb       (wb),
        .dm_stall (dm_stall)
    );

    mem_stage_monitor u_monitor (
        .clk      (clk),
        .reset    (reset),
        .exe      (exe),
        .im_stall (im_stall),
        .dm_stall (dm_stall),
        .wb       (wb),
        .done     (done),
        .errors   (mon_errors),
        .pending  (pending)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // Two LFSR bits give a gap of 0 to 3 cycles
    function automatic int pick_gap(input logic [2:0] col);
        logic [1:0] g;
        if (col != RND) begin
            return int'(col);
        end
        lfsr = lfsr_step(lfsr);
        g[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        g[1] = lfsr[0];
        return int'(g);
    endfunction

    function automatic exe_out_t make_exe(input row_t r, input int i);
        exe_out_t e;
        e             = '0;
        e.valid       = 1'b1;
        e.alu_out     = r.addr;
        e.r_alu_out   = r.link;
        e.write_addr  = r.waddr;
        e.funct3      = r.f3;
        e.pc          = 32'h0000_1000 + xlen_t'(i) * 32'd4;
        e.store_data  = r.data;
        e.rd_src      = r.rd_src;
        e.mem_to_reg  = (r.kind == K_LOAD);
        e.mem_write   = (r.kind == K_STORE);
        e.mem_read    = (r.kind == K_LOAD);
        e.reg_write   = r.wr[0];
        e.f_reg_write = r.wr[1];
        return e;
    endfunction

    initial begin
        // Stores at every lane, then loads of every width and offset
        rows[0]  = '{K_STORE, F3_W,  32'h100, 32'h1122_3344, 2'b00, 1'b0, 32'h0, 5'd0,  3'd0};
        rows[1]  = '{K_STORE, F3_B,  32'h101, 32'h0000_00a5, 2'b00, 1'b0, 32'h0, 5'd0,  RND};
        rows[2]  = '{K_STORE, F3_B,  32'h103, 32'h0000_007f, 2'b00, 1'b0, 32'h0, 5'd0,  RND};
        rows[3]  = '{K_LOAD,  F3_W,  32'h100, 32'h0,         2'b01, 1'b0, 32'h0, 5'd1,  3'd0};
        rows[4]  = '{K_STORE, F3_H,  32'h102, 32'h0000_beef, 2'b00, 1'b0, 32'h0, 5'd0,  RND};
        rows[5]  = '{K_STORE, F3_B,  32'h100, 32'h0000_0080, 2'b00, 1'b0, 32'h0, 5'd0,  RND};
        rows[6]  = '{K_LOAD,  F3_B,  32'h100, 32'h0,         2'b01, 1'b0, 32'h0, 5'd2,  RND};
        rows[7]  = '{K_LOAD,  F3_B,  32'h101, 32'h0,         2'b01, 1'b0, 32'h0, 5'd3,  3'd0};
        rows[8]  = '{K_LOAD,  F3_BU, 32'h102, 32'h0,         2'b01, 1'b0, 32'h0, 5'd4,  RND};
        rows[9]  = '{K_LOAD,  F3_BU, 32'h103, 32'h0,         2'b01, 1'b0, 32'h0, 5'd5,  RND};
        rows[10] = '{K_LOAD,  F3_H,  32'h100, 32'h0,         2'b01, 1'b0, 32'h0, 5'd6,  3'd0};
        rows[11] = '{K_LOAD,  F3_H,  32'h102, 32'h0,         2'b01, 1'b0, 32'h0, 5'd7,  RND};
        rows[12] = '{K_LOAD,  F3_HU, 32'h100, 32'h0,         2'b01, 1'b0, 32'h0, 5'd8,  RND};
        rows[13] = '{K_LOAD,  F3_HU, 32'h102, 32'h0,         2'b01, 1'b0, 32'h0, 5'd9,  3'd0};
        rows[14] = '{K_ALU,   F3_W,  32'h1234_5678, 32'h0,   2'b01, 1'b0, 32'h0, 5'd10, RND};
        rows[15] = '{K_ALU,   F3_W,  32'h0000_dead, 32'h0,   2'b01, 1'b1, 32'h1040, 5'd11, RND};
        // FSW then FLW through the word path
        rows[16] = '{K_STORE, F3_W,  32'h104, 32'h3f80_0000, 2'b00, 1'b0, 32'h0, 5'd0,  RND};
        rows[17] = '{K_LOAD,  F3_W,  32'h104, 32'h0,         2'b10, 1'b0, 32'h0, 5'd3,  RND};
        rows[18] = '{K_STORE, F3_B,  32'h102, 32'h0000_005a, 2'b00, 1'b0, 32'h0, 5'd0,  3'd3};
        rows[19] = '{K_STORE, F3_H,  32'h100, 32'h0000_0123, 2'b00, 1'b0, 32'h0, 5'd0,  RND};
        rows[20] = '{K_ALU,   F3_W,  32'h0000_0042, 32'h0,   2'b00, 1'b0, 32'h0, 5'd12, RND};
        // Read-back rows catch a store applied twice
        rows[21] = '{K_LOAD,  F3_W,  32'h100, 32'h0,         2'b01, 1'b0, 32'h0, 5'd13, RND};
        rows[22] = '{K_LOAD,  F3_B,  32'h103, 32'h0,         2'b01, 1'b0, 32'h0, 5'd14, 3'd0};
        rows[23] = '{K_LOAD,  F3_W,  32'h104, 32'h0,         2'b01, 1'b0, 32'h0, 5'd15, RND};
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
                $display("Simulation FAILED");
                $finish;
            end
        end
    end

    initial begin
        int   gap;
        int   drain;
        logic captured;
        reset     = 1'b1;
        exe       = '0;
        im_stall  = 1'b0;
        done      = 1'b0;
        lfsr      = 32'h0821_bb95;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Idle cycles before the first row
        repeat (4) @(posedge clk);

        for (int i = 0; i < N_ROWS; i++) begin
            gap = pick_gap(rows[i].gap);
            exe      <= make_exe(rows[i], i);
            im_stall <= (gap != 0);
            captured = 1'b0;
            while (!captured) begin
                @(posedge clk);
                if (!im_stall && !dm_stall) begin
                    captured = 1'b1;
                end else if (gap != 0) begin
                    gap--;
                    if (gap == 0) begin
                        im_stall <= 1'b0;
                    end
                end
            end
        end
        exe <= '0;

        // The last row retires within a few cycles of its capture
        drain = 0;
        while (pending != 0 && drain < DRAIN_MAX) begin
            @(posedge clk);
            drain++;
        end
        repeat (4) @(posedge clk);
        done <= 1'b1;
        repeat (2) @(posedge clk);

        $display("Errors: %0d", mon_errors);
        if (mon_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/rv_mem_pkg.sv
hdl/exe_mem_reg.sv
hdl/data_mem.sv
hdl/mem_wb_reg.sv
hdl/mem_stage_top.sv
test/mem_stage_properties.sv
test/mem_stage_monitor.sv
test/mem_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED

BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure found in $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
